// File: filelist.f
+incdir+.
rv_exec_pkg.sv
exec_ctrl_if.sv
op_decode.sv
exec_alu.sv
branch_unit.sv
mem_request.sv
trap_control.sv
result_stage.sv
execute_stage.sv
tb_execute_stage.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --timing
TOP       ?= tb_execute_stage
FILELIST  ?= filelist.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_execute_stage.sv
// Random self-checking test, seed 74. One instruction per cycle, checks settle at the falling edge
`timescale 1ns/1ps
`include "rv_exec_config.svh"

module tb_execute_stage;
    import rv_exec_pkg::*;

    localparam int SEED           = 74;
    localparam int RANDOM_CYCLES  = 2000;
    localparam int KILL_ROUNDS    = 40;
    localparam int REDIRECT_LIMIT = 8;
    localparam int MODE_RANDOM    = 0;
    localparam int MODE_JUMP      = 1;
    localparam int MODE_STALE     = 2;

    logic      clk;
    logic      reset;
    logic      stall_i;
    op_e       op_i;
    word_t     pc_i;
    word_t     op_a_i;
    word_t     op_b_i;
    word_t     op_c_i;
    tag_t      tag_i;
    logic      illegal_i;
    logic      misaligned_i;
    logic      irq_pending_i;

    logic      killed_o;
    logic      write_enable_o;
    op_e       operation_o;
    word_t     result_o;
    word_t     mem_addr_o;
    logic      mem_read_en_o;
    byte_en_t  mem_write_en_o;
    word_t     mem_write_data_o;
    logic      jump_o;
    word_t     jump_target_o;
    logic      raise_exception_o;
    exc_code_e exception_code_o;
    logic      machine_return_o;
    logic      interrupt_ack_o;

    // Reference model state
    tag_t        model_tag;
    logic        exp_we;
    op_e         exp_op;
    word_t       exp_result;
    logic        result_valid;

    execute_stage UUT (.*);

    always #4 clk = ~clk;

    ////////////////////
    // Reference model
    ////////////////////

    function automatic word_t alu_result(op_e op, word_t pc, word_t a, word_t b);
        case (op)
            SUB:       return a - b;
            AND:       return a & b;
            OR:        return a | b;
            XOR:       return a ^ b;
            SLL:       return a << b[4:0];
            SRL:       return a >> b[4:0];
            SRA:       return word_t'($signed(a) >>> b[4:0]);
            SLT:       return word_t'($signed(a) < $signed(b));
            SLTU:      return word_t'(a < b);
            LUI:       return b;
            JAL, JALR: return pc + `EXEC_LINK_OFFSET;
            default:   return a + b;
        endcase
    endfunction

    function automatic logic branch_taken(op_e op, word_t a, word_t b);
        case (op)
            JAL, JALR: return 1'b1;
            BEQ:       return a == b;
            BNE:       return a != b;
            BLT:       return $signed(a) < $signed(b);
            BLTU:      return a < b;
            BGE:       return $signed(a) >= $signed(b);
            BGEU:      return a >= b;
            default:   return 1'b0;
        endcase
    endfunction

    function automatic word_t jump_target(op_e op, word_t pc, word_t a, word_t b, word_t c);
        word_t s;
        s = a + b;
        if (op == JAL) return s;
        if (op == JALR) return {s[`EXEC_XLEN-1:1], 1'b0};
        return pc + c;
    endfunction

    function automatic logic is_control(op_e op);
        return op inside {JAL, JALR, BEQ, BNE, BLT, BLTU, BGE, BGEU};
    endfunction

    function automatic logic is_load(op_e op);
        return op inside {LB, LBU, LH, LHU, LW};
    endfunction

    function automatic logic writes_register(op_e op);
        return !(op inside {BEQ, BNE, BLT, BLTU, BGE, BGEU, SB, SH, SW});
    endfunction

    function automatic byte_en_t store_lanes(op_e op, word_t sum);
        case (op)
            SB:      return 4'b0001 << sum[1:0];
            SH:      return sum[1] ? 4'b1100 : 4'b0011;
            SW:      return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    function automatic word_t store_data(op_e op, word_t c);
        if (op == SB) return {4{c[7:0]}};
        if (op == SH) return {2{c[15:0]}};
        return c;
    endfunction

    // Single highest priority trap for a live instruction
    task automatic predict_trap(input op_e op, input logic killed, output logic raise,
                                output exc_code_e code, output logic mret, output logic ack);
        raise = 1'b0;
        mret  = 1'b0;
        ack   = 1'b0;
        code  = NE;
        if (!killed) begin
            if (illegal_i) begin
                raise = 1'b1;
                code  = ILLEGAL_INSTRUCTION;
            end else if (misaligned_i) begin
                raise = 1'b1;
                code  = INSTRUCTION_ADDRESS_MISALIGNED;
            end else if (op == ECALL) begin
                raise = 1'b1;
                code  = ECALL_FROM_MMODE;
            end else if (op == EBREAK) begin
                raise = 1'b1;
                code  = BREAKPOINT;
            end else if (op == MRET) begin
                mret = 1'b1;
            end else if (irq_pending_i && op != NOP) begin
                ack = 1'b1;
            end
        end
    endtask

    // Clock edge as seen by the DUT, inputs still hold the sampled values
    task automatic update_model();
        logic      killed;
        logic      raise;
        exc_code_e code;
        logic      mret;
        logic      ack;
        logic      redirect;
        killed = (tag_i != model_tag);
        predict_trap(op_i, killed, raise, code, mret, ack);
        redirect = (!killed && branch_taken(op_i, op_a_i, op_b_i)) || raise || mret || ack;
        if (!stall_i) begin
            if (redirect) model_tag = model_tag + 1'b1;
            exp_we       = writes_register(op_i) && !killed;
            exp_op       = op_i;
            exp_result   = alu_result(op_i, pc_i, op_a_i, op_b_i);
            result_valid = 1'b1;
        end
    endtask

    ////////////////////
    // Checking
    ////////////////////

    task automatic check_value(input string what, input word_t got, input word_t expected);
        if (got !== expected) begin
            $display("Error at time %0t: %s is %h, expected %h", $time, what, got, expected);
            $display("*** TEST FAILED ***");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic check_outputs();
        logic      killed;
        logic      raise;
        exc_code_e code;
        logic      mret;
        logic      ack;
        word_t     sum;
        killed = (tag_i != model_tag);
        predict_trap(op_i, killed, raise, code, mret, ack);
        sum = op_a_i + op_b_i;
        check_value("killed_o", word_t'(killed_o), word_t'(killed));
        check_value("jump_o", word_t'(jump_o),
                    word_t'(!killed && branch_taken(op_i, op_a_i, op_b_i)));
        if (is_control(op_i)) begin
            check_value("jump_target_o", jump_target_o,
                        jump_target(op_i, pc_i, op_a_i, op_b_i, op_c_i));
        end
        check_value("mem_addr_o", mem_addr_o, {sum[`EXEC_XLEN-1:2], 2'b00});
        check_value("mem_read_en_o", word_t'(mem_read_en_o), word_t'(is_load(op_i)));
        check_value("mem_write_en_o", word_t'(mem_write_en_o), word_t'(store_lanes(op_i, sum)));
        if (store_lanes(op_i, sum) != 4'b0000) begin
            check_value("mem_write_data_o", mem_write_data_o, store_data(op_i, op_c_i));
        end
        check_value("raise_exception_o", word_t'(raise_exception_o), word_t'(raise));
        check_value("exception_code_o", word_t'(exception_code_o), word_t'(code));
        check_value("machine_return_o", word_t'(machine_return_o), word_t'(mret));
        check_value("interrupt_ack_o", word_t'(interrupt_ack_o), word_t'(ack));
        check_value("write_enable_o", word_t'(write_enable_o), word_t'(exp_we));
        check_value("operation_o", word_t'(operation_o), word_t'(exp_op));
        if (result_valid) check_value("result_o", result_o, exp_result);
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    task automatic drive_inputs(input int mode);
        word_t a;
        op_e   op;
        a  = $urandom;
        op = op_e'($urandom_range(0, 30));
        if (mode == MODE_JUMP) op = JAL;
        op_i   <= op;
        pc_i   <= $urandom & 32'hFFFF_FFFC;
        op_a_i <= a;
        // Equal operands now and then so eq and ne both get exercised
        op_b_i <= ($urandom_range(0, 3) == 0) ? a : $urandom;
        op_c_i <= $urandom;
        if (mode == MODE_STALE) begin
            tag_i <= model_tag - 1'b1;
        end else if (mode == MODE_RANDOM && $urandom_range(0, 3) == 0) begin
            tag_i <= tag_t'($urandom);
        end else begin
            tag_i <= model_tag;
        end
        stall_i       <= (mode == MODE_RANDOM) && ($urandom_range(0, 3) == 0);
        illegal_i     <= (mode != MODE_JUMP) && ($urandom_range(0, 15) == 0);
        misaligned_i  <= (mode != MODE_JUMP) && ($urandom_range(0, 15) == 0);
        irq_pending_i <= (mode != MODE_JUMP) && ($urandom_range(0, 7) == 0);
    endtask

    task automatic run_cycle(input int mode);
        @(posedge clk);
        update_model();
        drive_inputs(mode);
        @(negedge clk);
        check_outputs();
    endtask

    // Issue jumps on the current tag until the DUT redirects
    task automatic await_redirect();
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen) begin
            if (cycles == REDIRECT_LIMIT) begin
                $display("Timeout: no jump was taken within %0d cycles", REDIRECT_LIMIT);
                $display("*** TEST FAILED ***");
                $fatal(1, "Redirect wait timed out");
            end
            run_cycle(MODE_JUMP);
            seen   = jump_o;
            cycles = cycles + 1;
        end
    endtask

    initial begin
        void'($urandom(SEED));
        clk           = 1'b0;
        reset         = 1'b1;
        stall_i       = 1'b0;
        op_i          = ADD;
        pc_i          = '0;
        op_a_i        = '0;
        op_b_i        = '0;
        op_c_i        = '0;
        tag_i         = '0;
        illegal_i     = 1'b1;
        misaligned_i  = 1'b0;
        irq_pending_i = 1'b1;
        model_tag     = '0;
        exp_we        = 1'b0;
        exp_op        = NOP;
        exp_result    = '0;
        result_valid  = 1'b0;

        // Pending trap sources must stay quiet while reset is high
        repeat (2) @(posedge clk);
        @(negedge clk);
        check_value("raise_exception_o in reset", word_t'(raise_exception_o), '0);
        @(posedge clk);
        illegal_i     <= 1'b0;
        @(negedge clk);
        check_value("interrupt_ack_o in reset", word_t'(interrupt_ack_o), '0);
        repeat (2) @(posedge clk);
        reset         <= 1'b0;
        op_i          <= NOP;
        irq_pending_i <= 1'b0;
        @(negedge clk);
        check_value("write_enable_o after reset", word_t'(write_enable_o), '0);

        repeat (RANDOM_CYCLES) run_cycle(MODE_RANDOM);

        repeat (KILL_ROUNDS) begin
            await_redirect();
            repeat ($urandom_range(1, 3)) run_cycle(MODE_STALE);
            run_cycle(MODE_RANDOM);
        end

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: execute_stage.sv
// Stall freezes the output register and tag only. Memory and trap outputs stay combinational
`timescale 1ns/1ps

module execute_stage (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_i,

    input  rv_exec_pkg::op_e        op_i,
    input  rv_exec_pkg::word_t      pc_i,
    input  rv_exec_pkg::word_t      op_a_i,
    input  rv_exec_pkg::word_t      op_b_i,
    input  rv_exec_pkg::word_t      op_c_i,
    input  rv_exec_pkg::tag_t       tag_i,
    input  logic                    illegal_i,
    input  logic                    misaligned_i,
    input  logic                    irq_pending_i,

    output logic                    killed_o,
    output logic                    write_enable_o,
    output rv_exec_pkg::op_e        operation_o,
    output rv_exec_pkg::word_t      result_o,

    output rv_exec_pkg::word_t      mem_addr_o,
    output logic                    mem_read_en_o,
    output rv_exec_pkg::byte_en_t   mem_write_en_o,
    output rv_exec_pkg::word_t      mem_write_data_o,

    output logic                    jump_o,
    output rv_exec_pkg::word_t      jump_target_o,

    output logic                    raise_exception_o,
    output rv_exec_pkg::exc_code_e  exception_code_o,
    output logic                    machine_return_o,
    output logic                    interrupt_ack_o
);
    import rv_exec_pkg::*;

    word_t alu_result;
    logic  branch_taken;

    exec_ctrl_if ctrl_bus ();

    ////////////////////
    // Decode
    ////////////////////

    op_decode u_decode (
        .op_i   (op_i),
        .ctrl   (ctrl_bus.decode_mp)
    );

    ////////////////////
    // Execute
    ////////////////////

    exec_alu u_alu (
        .ctrl     (ctrl_bus.unit_mp),
        .op_a_i   (op_a_i),
        .op_b_i   (op_b_i),
        .result_o (alu_result)
    );

    branch_unit u_branch (
        .ctrl     (ctrl_bus.unit_mp),
        .pc_i     (pc_i),
        .op_a_i   (op_a_i),
        .op_b_i   (op_b_i),
        .op_c_i   (op_c_i),
        .taken_o  (branch_taken),
        .target_o (jump_target_o)
    );

    mem_request u_mem (
        .ctrl         (ctrl_bus.unit_mp),
        .op_a_i       (op_a_i),
        .op_b_i       (op_b_i),
        .op_c_i       (op_c_i),
        .addr_o       (mem_addr_o),
        .read_en_o    (mem_read_en_o),
        .write_en_o   (mem_write_en_o),
        .write_data_o (mem_write_data_o)
    );

    ////////////////////
    // Result
    ////////////////////

    trap_control u_trap (
        .clk               (clk),
        .reset             (reset),
        .stall_i           (stall_i),
        .tag_i             (tag_i),
        .ctrl              (ctrl_bus.unit_mp),
        .op_i              (op_i),
        .illegal_i         (illegal_i),
        .misaligned_i      (misaligned_i),
        .irq_pending_i     (irq_pending_i),
        .branch_taken_i    (branch_taken),
        .killed_o          (killed_o),
        .jump_o            (jump_o),
        .raise_exception_o (raise_exception_o),
        .machine_return_o  (machine_return_o),
        .interrupt_ack_o   (interrupt_ack_o),
        .exception_code_o  (exception_code_o)
    );

    result_stage u_result (
        .clk            (clk),
        .reset          (reset),
        .stall_i        (stall_i),
        .ctrl           (ctrl_bus.unit_mp),
        .op_i           (op_i),
        .killed_i       (killed_o),
        .pc_i           (pc_i),
        .op_b_i         (op_b_i),
        .alu_result_i   (alu_result),
        .result_o       (result_o),
        .write_enable_o (write_enable_o),
        .operation_o    (operation_o)
    );

endmodule

// File: result_stage.sv
// Result data is undefined until the first edge with stall low after reset
`timescale 1ns/1ps
`include "rv_exec_config.svh"

module result_stage (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall_i,
    exec_ctrl_if.unit_mp         ctrl,
    input  rv_exec_pkg::op_e     op_i,
    input  logic                 killed_i,
    input  rv_exec_pkg::word_t   pc_i,
    input  rv_exec_pkg::word_t   op_b_i,
    input  rv_exec_pkg::word_t   alu_result_i,
    output rv_exec_pkg::word_t   result_o,
    output logic                 write_enable_o,
    output rv_exec_pkg::op_e     operation_o
);
    import rv_exec_pkg::*;

    word_t result;

    // Link address, then lui immediate, then ALU
    always_comb begin
        if (ctrl.link_sel) begin
            result = pc_i + word_t'(`EXEC_LINK_OFFSET);
        end else if (ctrl.lui_sel) begin
            result = op_b_i;
        end else begin
            result = alu_result_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            write_enable_o <= 1'b0;
            operation_o    <= NOP;
        end else if (!stall_i) begin
            write_enable_o <= ctrl.writes_reg && !killed_i;
            operation_o    <= op_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            result_o <= result;
        end
    end

endmodule

// File: trap_control.sv
// One instruction in flight. The tag wraps after eight redirects without a check
`timescale 1ns/1ps

module trap_control (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    stall_i,
    input  rv_exec_pkg::tag_t       tag_i,
    exec_ctrl_if.unit_mp            ctrl,
    input  rv_exec_pkg::op_e        op_i,
    input  logic                    illegal_i,
    input  logic                    misaligned_i,
    input  logic                    irq_pending_i,
    input  logic                    branch_taken_i,
    output logic                    killed_o,
    output logic                    jump_o,
    output logic                    raise_exception_o,
    output logic                    machine_return_o,
    output logic                    interrupt_ack_o,
    output rv_exec_pkg::exc_code_e  exception_code_o
);
    import rv_exec_pkg::*;

    tag_t curr_tag;
    logic redirect;

    ////////////////////
    // Kill detection
    ////////////////////

    // Wrong-path instructions still carry the tag from before the redirect
    assign killed_o = (curr_tag != tag_i);
    assign jump_o   = branch_taken_i && !killed_o;
    assign redirect = jump_o || raise_exception_o || machine_return_o || interrupt_ack_o;

    always_ff @(posedge clk) begin
        if (reset) begin
            curr_tag <= '0;
        end else if (!stall_i && redirect) begin
            curr_tag <= curr_tag + 1'b1;
        end
    end

    ////////////////////
    // Trap priority
    ////////////////////

    always_comb begin
        raise_exception_o = 1'b0;
        machine_return_o  = 1'b0;
        interrupt_ack_o   = 1'b0;
        exception_code_o  = NE;
        if (!reset && !killed_o) begin
            if (illegal_i) begin
                raise_exception_o = 1'b1;
                exception_code_o  = ILLEGAL_INSTRUCTION;
            end else if (misaligned_i) begin
                raise_exception_o = 1'b1;
                exception_code_o  = INSTRUCTION_ADDRESS_MISALIGNED;
            end else if (ctrl.ecall) begin
                raise_exception_o = 1'b1;
                exception_code_o  = ECALL_FROM_MMODE;
            end else if (ctrl.ebreak) begin
                raise_exception_o = 1'b1;
                exception_code_o  = BREAKPOINT;
            end else if (ctrl.mret) begin
                machine_return_o  = 1'b1;
            end else if (irq_pending_i && op_i != NOP) begin
                // Interrupts are only taken on a real instruction
                interrupt_ack_o   = 1'b1;
            end
        end
    end

endmodule

// File: mem_request.sv
// Word-addressed bus. Misaligned half and word stores are not detected
`timescale 1ns/1ps

module mem_request (
    exec_ctrl_if.unit_mp           ctrl,
    input  rv_exec_pkg::word_t     op_a_i,
    input  rv_exec_pkg::word_t     op_b_i,
    input  rv_exec_pkg::word_t     op_c_i,
    output rv_exec_pkg::word_t     addr_o,
    output logic                   read_en_o,
    output rv_exec_pkg::byte_en_t  write_en_o,
    output rv_exec_pkg::word_t     write_data_o
);
    import rv_exec_pkg::*;

    word_t sum;

    assign sum       = op_a_i + op_b_i;
    // Byte offset goes to the lane enables, not the address
    assign addr_o    = {sum[$bits(word_t)-1:2], 2'b00};
    assign read_en_o = (ctrl.mem_op == MEM_LOAD);

    always_comb begin
        unique case (ctrl.mem_op)
            MEM_SB:  write_en_o = byte_en_t'(1) << sum[1:0];
            MEM_SH:  write_en_o = sum[1] ? 4'b1100 : 4'b0011;
            MEM_SW:  write_en_o = '1;
            default: write_en_o = '0;
        endcase
    end

    // Store data replicated so every lane sees it
    always_comb begin
        unique case (ctrl.mem_op)
            MEM_SB:  write_data_o = {4{op_c_i[7:0]}};
            MEM_SH:  write_data_o = {2{op_c_i[15:0]}};
            default: write_data_o = op_c_i;
        endcase
    end

endmodule

// File: branch_unit.sv
// Targets are not checked for alignment. Misaligned fetch is flagged upstream
`timescale 1ns/1ps

module branch_unit (
    exec_ctrl_if.unit_mp         ctrl,
    input  rv_exec_pkg::word_t   pc_i,
    input  rv_exec_pkg::word_t   op_a_i,
    input  rv_exec_pkg::word_t   op_b_i,
    input  rv_exec_pkg::word_t   op_c_i,
    output logic                 taken_o,
    output rv_exec_pkg::word_t   target_o
);
    import rv_exec_pkg::*;

    word_t jump_sum;
    logic  equal;
    logic  lt_signed;
    logic  lt_unsigned;

    assign equal       = op_a_i == op_b_i;
    assign lt_signed   = $signed(op_a_i) < $signed(op_b_i);
    assign lt_unsigned = op_a_i < op_b_i;

    always_comb begin
        unique case (ctrl.branch_cond)
            BR_ALWAYS: taken_o = 1'b1;
            BR_EQ:     taken_o = equal;
            BR_NE:     taken_o = !equal;
            BR_LT:     taken_o = lt_signed;
            BR_LTU:    taken_o = lt_unsigned;
            BR_GE:     taken_o = !lt_signed;
            BR_GEU:    taken_o = !lt_unsigned;
            default:   taken_o = 1'b0;
        endcase
    end

    // Jumps use register plus offset, branches are pc relative
    assign jump_sum = op_a_i + op_b_i;

    always_comb begin
        if (ctrl.link_sel) begin
            target_o = ctrl.jalr_sel ? {jump_sum[$bits(word_t)-1:1], 1'b0} : jump_sum;
        end else begin
            target_o = pc_i + op_c_i;
        end
    end

endmodule

// File: exec_alu.sv
// Shifts use only the low bits of op_b. No overflow or carry reported
`timescale 1ns/1ps

module exec_alu (
    exec_ctrl_if.unit_mp         ctrl,
    input  rv_exec_pkg::word_t   op_a_i,
    input  rv_exec_pkg::word_t   op_b_i,
    output rv_exec_pkg::word_t   result_o
);
    import rv_exec_pkg::*;

    shamt_t shamt;
    logic   lt_signed;
    logic   lt_unsigned;

    assign shamt = op_b_i[$bits(shamt_t)-1:0];

    ////////////////////
    // Compare
    ////////////////////

    assign lt_signed   = $signed(op_a_i) < $signed(op_b_i);
    assign lt_unsigned = op_a_i < op_b_i;

    ////////////////////
    // Function select
    ////////////////////

    always_comb begin
        unique case (ctrl.alu_op)
            ALU_SUB:  result_o = op_a_i - op_b_i;
            ALU_AND:  result_o = op_a_i & op_b_i;
            ALU_OR:   result_o = op_a_i | op_b_i;
            ALU_XOR:  result_o = op_a_i ^ op_b_i;
            ALU_SLL:  result_o = op_a_i << shamt;
            ALU_SRL:  result_o = op_a_i >> shamt;
            // Arithmetic shift keeps the sign bit
            ALU_SRA:  result_o = word_t'($signed(op_a_i) >>> shamt);
            ALU_SLT:  result_o = word_t'(lt_signed);
            ALU_SLTU: result_o = word_t'(lt_unsigned);
            default:  result_o = op_a_i + op_b_i;
        endcase
    end

endmodule

// File: op_decode.sv
// Loads form one class here. Load data sign extension happens after this stage
`timescale 1ns/1ps

module op_decode (
    input  rv_exec_pkg::op_e     op_i,
    exec_ctrl_if.decode_mp       ctrl
);
    import rv_exec_pkg::*;

    always_comb begin
        // Plain register-writing add unless the operation says otherwise
        ctrl.alu_op      = ALU_ADD;
        ctrl.branch_cond = BR_NEVER;
        ctrl.mem_op      = MEM_NONE;
        ctrl.link_sel    = 1'b0;
        ctrl.jalr_sel    = 1'b0;
        ctrl.lui_sel     = 1'b0;
        ctrl.writes_reg  = 1'b1;
        ctrl.ecall       = 1'b0;
        ctrl.ebreak      = 1'b0;
        ctrl.mret        = 1'b0;

        unique case (op_i)
            SUB:  ctrl.alu_op = ALU_SUB;
            AND:  ctrl.alu_op = ALU_AND;
            OR:   ctrl.alu_op = ALU_OR;
            XOR:  ctrl.alu_op = ALU_XOR;
            SLL:  ctrl.alu_op = ALU_SLL;
            SRL:  ctrl.alu_op = ALU_SRL;
            SRA:  ctrl.alu_op = ALU_SRA;
            SLT:  ctrl.alu_op = ALU_SLT;
            SLTU: ctrl.alu_op = ALU_SLTU;
            LUI:  ctrl.lui_sel = 1'b1;
            JAL, JALR: begin
                ctrl.branch_cond = BR_ALWAYS;
                ctrl.link_sel    = 1'b1;
                ctrl.jalr_sel    = (op_i == JALR);
            end
            BEQ:  begin ctrl.branch_cond = BR_EQ;  ctrl.writes_reg = 1'b0; end
            BNE:  begin ctrl.branch_cond = BR_NE;  ctrl.writes_reg = 1'b0; end
            BLT:  begin ctrl.branch_cond = BR_LT;  ctrl.writes_reg = 1'b0; end
            BLTU: begin ctrl.branch_cond = BR_LTU; ctrl.writes_reg = 1'b0; end
            BGE:  begin ctrl.branch_cond = BR_GE;  ctrl.writes_reg = 1'b0; end
            BGEU: begin ctrl.branch_cond = BR_GEU; ctrl.writes_reg = 1'b0; end
            LB, LBU, LH, LHU, LW: ctrl.mem_op = MEM_LOAD;
            SB:   begin ctrl.mem_op = MEM_SB; ctrl.writes_reg = 1'b0; end
            SH:   begin ctrl.mem_op = MEM_SH; ctrl.writes_reg = 1'b0; end
            SW:   begin ctrl.mem_op = MEM_SW; ctrl.writes_reg = 1'b0; end
            ECALL:  ctrl.ecall  = 1'b1;
            EBREAK: ctrl.ebreak = 1'b1;
            MRET:   ctrl.mret   = 1'b1;
            default: ;
        endcase
    end

endmodule

// File: exec_ctrl_if.sv
// Decoded control for the one instruction in the stage. Combinational, no handshake
`timescale 1ns/1ps

interface exec_ctrl_if;
    import rv_exec_pkg::*;

    alu_op_e      alu_op;
    branch_cond_e branch_cond;
    mem_op_e      mem_op;
    // Result is pc plus the link offset
    logic         link_sel;
    // Jump target needs bit 0 cleared
    logic         jalr_sel;
    logic         lui_sel;
    logic         writes_reg;
    logic         ecall;
    logic         ebreak;
    logic         mret;

    modport decode_mp (
        output alu_op, branch_cond, mem_op, link_sel, jalr_sel, lui_sel,
               writes_reg, ecall, ebreak, mret
    );

    modport unit_mp (
        input  alu_op, branch_cond, mem_op, link_sel, jalr_sel, lui_sel,
               writes_reg, ecall, ebreak, mret
    );

endinterface

// File: rv_exec_pkg.sv
// Shared types for the execute stage. op_e holds at most 32 operations in its 5 bits
`include "rv_exec_config.svh"

package rv_exec_pkg;

    typedef logic [`EXEC_XLEN-1:0]    word_t;
    typedef logic [`EXEC_TAG_W-1:0]   tag_t;
    typedef logic [`EXEC_SHAMT_W-1:0] shamt_t;
    typedef logic [`EXEC_BE_W-1:0]    byte_en_t;

    // Operation delivered by the decode stage
    typedef enum logic [4:0] {
        NOP, ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU, LUI,
        JAL, JALR, BEQ, BNE, BLT, BLTU, BGE, BGEU,
        LB, LBU, LH, LHU, LW, SB, SH, SW,
        ECALL, EBREAK, MRET
    } op_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NEVER, BR_ALWAYS, BR_EQ, BR_NE, BR_LT, BR_LTU, BR_GE, BR_GEU
    } branch_cond_e;

    typedef enum logic [2:0] {
        MEM_NONE, MEM_LOAD, MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    // RISC-V mcause values, NE marks no exception
    typedef enum logic [3:0] {
        INSTRUCTION_ADDRESS_MISALIGNED = 4'd0,
        ILLEGAL_INSTRUCTION            = 4'd2,
        BREAKPOINT                     = 4'd3,
        ECALL_FROM_MMODE               = 4'd11,
        NE                             = 4'd15
    } exc_code_e;

endpackage

// File: rv_exec_config.svh
// RV32 only. EXEC_BE_W must stay EXEC_XLEN/8 and EXEC_SHAMT_W must stay log2 of EXEC_XLEN
`ifndef RV_EXEC_CONFIG_SVH
`define RV_EXEC_CONFIG_SVH

// Data path width
`define EXEC_XLEN        32

// Flow tag width, sets how many redirects can be told apart
`define EXEC_TAG_W       3

// Instruction size added to pc for the link address
`define EXEC_LINK_OFFSET 4

`define EXEC_SHAMT_W     5
`define EXEC_BE_W        4

`endif
